//--- hw/kcpu_alu.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_alu import kcpu_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  logic        dec_valid,
    input  dec_t        dec,
    input  logic [15:0] quot,
    input  logic [ 7:0] rem,
    input  logic        div_v,
    input  logic        div_busy,
    output logic        div_start,
    output logic [15:0] div_num,
    output logic [ 7:0] div_den,
    output logic        done,
    output result_t     res
);

    localparam bit HAS_DIV  = `KCPU_HAS_DIV != 0;
    localparam bit HAS_LMUL = `KCPU_HAS_LMUL != 0;

    opnd_u       a;
    opnd_u       b;
    cc_t         cc_i;
    cc_t         cc_o;
    cc_t         div_cc;
    cc_t         pend_cc;
    logic [ 3:0] msb;
    logic [15:0] r;
    logic [15:0] r_hi;
    logic [16:0] sum;
    logic [16:0] dif;
    logic [ 8:0] sum8;
    logic [ 8:0] dif8;
    logic [ 7:0] daa_fix;
    logic [ 8:0] daa_sum;
    logic        cin;
    logic        keep_cc;
    logic        is_div;
    logic        pend;      // Divide in progress
    logic        pend_w16;

    assign a    = dec.opnd0;
    assign b    = dec.opnd1;
    assign cc_i = dec.cc;
    assign msb  = dec.w16 ? 4'd15 : 4'd7;
    assign cin  = (dec.op == op_adc || dec.op == op_sbc) ? cc_i.c : 1'b0;

    // Low byte of the wide sum is the byte sum, only the carry differs
    assign sum  = {1'b0, a.word} + {1'b0, b.word} + {16'd0, cin};
    assign dif  = {1'b0, a.word} - {1'b0, b.word} - {16'd0, cin};
    assign sum8 = {1'b0, a.bytes.lo} + {1'b0, b.bytes.lo} + {8'd0, cin};
    assign dif8 = {1'b0, a.bytes.lo} - {1'b0, b.bytes.lo} - {8'd0, cin};

    // BCD correction of the byte in B
    assign daa_fix[7:4] = (cc_i.c || a.bytes.lo[7:4] > 4'h9 ||
                           (a.bytes.lo[7:4] > 4'h8 && a.bytes.lo[3:0] > 4'h9)) ? 4'h6 : 4'h0;
    assign daa_fix[3:0] = (cc_i.h || a.bytes.lo[3:0] > 4'h9) ? 4'h6 : 4'h0;
    assign daa_sum      = {1'b0, a.bytes.lo} + {1'b0, daa_fix};

    always_comb begin
        r       = a.word;
        r_hi    = 16'h0000;
        cc_o    = cc_i;
        keep_cc = 1'b0;
        case (dec.op)
            op_ld: begin
                r      = b.word;
                cc_o.v = 1'b0;
            end
            op_add, op_adc: begin
                r      = sum[15:0];
                cc_o.c = dec.w16 ? sum[16] : sum8[8];
                cc_o.v = (a.word[msb] & b.word[msb] & ~r[msb]) |
                         (~a.word[msb] & ~b.word[msb] & r[msb]);
                if (!dec.w16)
                    cc_o.h = a.word[4] ^ b.word[4] ^ r[4];
            end
            op_sub, op_sbc, op_cmp: begin
                r      = dif[15:0];
                cc_o.c = dec.w16 ? dif[16] : dif8[8];   // Borrow
                cc_o.v = (a.word[msb] & ~b.word[msb] & ~r[msb]) |
                         (~a.word[msb] & b.word[msb] & r[msb]);
            end
            op_and: begin
                r      = a.word & b.word;
                cc_o.v = 1'b0;
            end
            op_eor: begin
                r      = a.word ^ b.word;
                cc_o.v = 1'b0;
            end
            op_or: begin
                r      = a.word | b.word;
                cc_o.v = 1'b0;
            end
            op_andcc: cc_o = cc_i & b.bytes.lo;
            op_orcc:  cc_o = cc_i | b.bytes.lo;
            op_clr: begin
                r      = 16'h0000;
                cc_o.c = 1'b0;
                cc_o.v = 1'b0;
            end
            op_com: begin
                r      = ~a.word;
                cc_o.c = 1'b1;
                cc_o.v = 1'b0;
            end
            op_neg: begin
                r      = 16'h0000 - a.word;
                cc_o.c = dec.w16 ? a.word != 16'h0000 : a.bytes.lo != 8'h00;
                cc_o.v = a.word[msb] == r[msb];
            end
            op_inc, op_dec: begin
                r      = dec.op == op_inc ? a.word + 16'd1 : a.word - 16'd1;
                cc_o.v = a.word[msb] ^ r[msb];  // Sign flipped
            end
            op_lsr, op_ror, op_asr: begin
                r      = a.word >> 1;
                cc_o.c = a.word[0];
                case (dec.op)
                    op_lsr:  r[msb] = 1'b0;
                    op_ror:  r[msb] = cc_i.c;
                    default: r[msb] = a.word[msb];
                endcase
            end
            op_asl, op_rol: begin
                r      = {a.word[14:0], dec.op == op_rol ? cc_i.c : 1'b0};
                cc_o.c = a.word[msb];
                cc_o.v = a.word[msb] ^ r[msb];
            end
            op_daa: begin
                r      = {a.bytes.hi, daa_sum[7:0]};
                cc_o.c = cc_i.c | daa_sum[8];
            end
            op_sex: r = {{8{a.bytes.lo[7]}}, a.bytes.lo};
            op_mul: begin
                r      = a.bytes.hi * a.bytes.lo;
                cc_o.c = r[7];
            end
            op_lmul: begin
                if (HAS_LMUL) begin
                    {r_hi, r} = a.word * b.word;
                    cc_o.c    = r_hi[15];
                end else begin
                    keep_cc = 1'b1;
                end
            end
            op_abs: begin
                if (a.word[msb])
                    r = dec.w16 ? 16'h0000 - a.word : {a.bytes.hi, 8'h00 - a.bytes.lo};
                cc_o.c = 1'b0;
                cc_o.v = 1'b0;
            end
            op_abx: r = {8'h00, a.bytes.lo} + b.word;
            default: keep_cc = 1'b1;                // div goes through the divider
        endcase

        if (!keep_cc) begin
            if (dec.up_z)
                cc_o.z = dec.w16 ? r == 16'h0000 : r[7:0] == 8'h00;
            if (dec.up_n)
                cc_o.n = r[msb];
        end
    end

    assign is_div    = HAS_DIV && dec.op == op_div;
    assign div_start = dec_valid && is_div;
    assign div_num   = a.word;
    assign div_den   = b.bytes.lo;

    always_comb begin
        div_cc   = pend_cc;
        div_cc.v = div_v;                           // Divide by zero
        div_cc.z = pend_w16 ? quot == 16'h0000 : quot[7:0] == 8'h00;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            done <= 1'b0;
            pend <= 1'b0;
            res  <= '0;
        end else begin
            done <= 1'b0;
            if (div_start)
                pend <= 1'b1;
            if (dec_valid && !is_div) begin
                res  <= '{rslt: r, rslt_hi: r_hi, cc: cc_o};
                done <= 1'b1;
            end else if (pend && !div_busy) begin  // Divider finished
                res  <= '{rslt: quot, rslt_hi: {8'h00, rem}, cc: div_cc};
                done <= 1'b1;
                pend <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (div_start) begin
            pend_cc  <= cc_i;
            pend_w16 <= dec.w16;
        end
    end

endmodule

//--- hw/kcpu_decode.sv
`timescale 1ns/1ps

module kcpu_decode import kcpu_pkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  logic   busy,
    input  logic   issue,
    input  issue_t issue_op,
    output logic   dec_valid,
    output dec_t   dec
);

    logic accept;
    logic div_in_dec;

    // Ops that leave N as it was
    function automatic logic writes_n(input alu_op_e op);
        case (op)
            op_abx,
            op_mul,
            op_lmul,
            op_div,
            op_andcc,
            op_orcc: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    // Ops that leave Z as it was
    function automatic logic writes_z(input alu_op_e op);
        case (op)
            op_abs,
            op_abx,
            op_andcc,
            op_orcc: return 1'b0;
            default: return 1'b1;
        endcase
    endfunction

    // A divide sitting here has not raised busy yet. Holding off for
    // that one cycle keeps a later op from overtaking it in the ALU
    assign div_in_dec = dec_valid && dec.op == op_div;
    assign accept     = issue && !busy && !div_in_dec;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            dec_valid <= 1'b0;
        end else begin
            dec_valid <= accept;    // One-cycle strobe into the ALU
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            dec.op    <= issue_op.op;
            dec.w16   <= issue_op.w16;
            dec.opnd0 <= issue_op.opnd0;
            dec.opnd1 <= issue_op.opnd1;
            dec.cc    <= issue_op.cc;
            dec.up_n  <= writes_n(issue_op.op);
            dec.up_z  <= writes_z(issue_op.op);
        end
    end

endmodule

//--- hw/kcpu_div.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_div (
    input  logic        clk,
    input  logic        rst,
    input  logic        start,
    input  logic [15:0] num,
    input  logic [ 7:0] den,
    output logic [15:0] quot,
    output logic [ 7:0] rem,
    output logic        v,
    output logic        busy
);

    localparam int CNT_W = $clog2(`KCPU_DIV_STEPS + 1);

    logic [CNT_W-1:0] cnt;      // Steps left
    logic [15:0]      q;        // Dividend shifts out, quotient shifts in
    logic [ 7:0]      r;        // Partial remainder
    logic [ 7:0]      d;
    logic             zero;
    logic [ 8:0]      trial;
    logic [ 8:0]      diff;
    logic             fits;
    logic             load;

    assign load  = start && !busy;
    assign trial = {r, q[15]};
    assign diff  = trial - {1'b0, d};
    assign fits  = trial >= {1'b0, d};
    assign busy  = cnt != '0;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt <= '0;
        end else if (load) begin
            cnt <= CNT_W'(`KCPU_DIV_STEPS);
        end else if (busy) begin
            cnt <= cnt - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (load) begin
            d    <= den;
            zero <= den == 8'h00;
            // Zero divisor returns all ones and the low byte untouched
            q    <= den == 8'h00 ? 16'hffff : num;
            r    <= den == 8'h00 ? num[7:0] : 8'h00;
        end else if (busy && !zero) begin
            r <= fits ? diff[7:0] : trial[7:0];    // Restore when it does not fit
            q <= {q[14:0], fits};
        end
    end

    // A 16/8 quotient always fits 16 bits, so V only flags a zero divisor
    assign quot = q;
    assign rem  = r;
    assign v    = zero;

endmodule

//--- hw/kcpu_exec.sv
`timescale 1ns/1ps

module kcpu_exec import kcpu_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    issue,
    input  issue_t  issue_op,
    output logic    busy,
    output logic    done,
    output result_t res
);

    logic        dec_valid;
    dec_t        dec;
    logic        div_start;
    logic [15:0] div_num;
    logic [ 7:0] div_den;
    logic [15:0] quot;
    logic [ 7:0] rem;
    logic        div_v;

    kcpu_decode decode_i (
        .clk       (clk),
        .rst       (rst),
        .busy      (busy),
        .issue     (issue),
        .issue_op  (issue_op),
        .dec_valid (dec_valid),
        .dec       (dec)
    );

    kcpu_alu alu_i (
        .clk       (clk),
        .rst       (rst),
        .dec_valid (dec_valid),
        .dec       (dec),
        .quot      (quot),
        .rem       (rem),
        .div_v     (div_v),
        .div_busy  (busy),         // Divider busy is the core busy
        .div_start (div_start),
        .div_num   (div_num),
        .div_den   (div_den),
        .done      (done),
        .res       (res)
    );

    kcpu_div div_i (
        .clk   (clk),
        .rst   (rst),
        .start (div_start),
        .num   (div_num),
        .den   (div_den),
        .quot  (quot),
        .rem   (rem),
        .v     (div_v),
        .busy  (busy)
    );

endmodule

//--- hw/kcpu_pkg.sv
package kcpu_pkg;

    typedef enum logic [5:0] {
        op_ld    = 6'd0,    // Load or test, result is opnd1
        op_add   = 6'd1,
        op_adc   = 6'd2,
        op_sub   = 6'd3,
        op_sbc   = 6'd4,
        op_cmp   = 6'd5,    // Same as sub, caller drops the result
        op_and   = 6'd6,
        op_eor   = 6'd7,
        op_or    = 6'd8,
        op_andcc = 6'd9,    // Mask in opnd1 low byte
        op_orcc  = 6'd10,
        op_clr   = 6'd11,
        op_com   = 6'd12,
        op_neg   = 6'd13,
        op_inc   = 6'd14,
        op_dec   = 6'd15,
        op_lsr   = 6'd16,
        op_ror   = 6'd17,
        op_asr   = 6'd18,
        op_asl   = 6'd19,
        op_rol   = 6'd20,
        op_daa   = 6'd21,
        op_sex   = 6'd22,
        op_mul   = 6'd23,   // A * B
        op_lmul  = 6'd24,   // 32-bit product
        op_abs   = 6'd25,
        op_abx   = 6'd26,   // X + B
        op_div   = 6'd27    // Multi-cycle
    } alu_op_e;

    typedef struct packed {
        logic e;            // Entire state stacked
        logic f;            // FIRQ mask
        logic h;            // Half carry
        logic i;            // IRQ mask
        logic n;
        logic z;
        logic v;
        logic c;
    } cc_t;

    typedef struct packed {
        logic [7:0] hi;     // A when the word is D
        logic [7:0] lo;     // B
    } opnd_bytes_t;

    // One operand word, either whole or split into A:B
    typedef union packed {
        logic [15:0] word;
        opnd_bytes_t bytes;
    } opnd_u;

    typedef struct packed {
        alu_op_e op;
        logic    w16;       // 16-bit form
        opnd_u   opnd0;     // Register operand
        opnd_u   opnd1;     // Memory operand
        cc_t     cc;
    } issue_t;

    typedef struct packed {
        alu_op_e op;
        logic    w16;
        opnd_u   opnd0;
        opnd_u   opnd1;
        cc_t     cc;
        logic    up_n;      // N is rewritten
        logic    up_z;      // Z is rewritten
    } dec_t;

    typedef struct packed {
        logic [15:0] rslt;
        logic [15:0] rslt_hi;   // lmul upper word, div remainder
        cc_t         cc;
    } result_t;

endpackage

//--- hw/kcpu_settings.svh
`ifndef KCPU_SETTINGS_SVH
`define KCPU_SETTINGS_SVH

// Optional units
// Set to 0 to leave the unit out. Its operation then returns opnd0
// and leaves the condition codes alone

`define KCPU_HAS_LMUL  1        // 16x16 long multiply
`define KCPU_HAS_DIV   1        // 16/8 unsigned divider

// Divider

// One quotient bit per step, so 16 covers the full dividend
`define KCPU_DIV_STEPS 16

`endif

//--- kcpu_exec.f
+incdir+hw
hw/kcpu_pkg.sv
hw/kcpu_decode.sv
hw/kcpu_div.sv
hw/kcpu_alu.sv
hw/kcpu_exec.sv
sim/kcpu_exec_asserts.sv
sim/kcpu_exec_tb.sv

//--- sim/kcpu_exec_asserts.sv
`timescale 1ns/1ps

module kcpu_exec_asserts import kcpu_pkg::*; (
    input logic   clk,
    input logic   rst,
    input logic   issue,
    input issue_t issue_op,
    input logic   busy,
    input logic   done,
    input logic   dec_valid,
    input dec_t   dec
);

    int fails = 0;          // Failed checks so far

    // The issuer must hold off while a divide runs
    no_issue_when_busy: assert property (
        @(posedge clk) disable iff (rst) !(issue && busy)
    ) else begin
        fails++;
        $error("issue pulsed while busy");
    end

    // A divide still in decode makes the decode stage drop the issue
    done_two_after_issue: assert property (
        @(posedge clk) disable iff (rst)
        issue && !busy && issue_op.op != op_div && !(dec_valid && dec.op == op_div)
            |-> ##2 done
    ) else begin
        fails++;
        $error("done missing two cycles after issue");
    end

    reset_leaves_idle: assert property (
        @(posedge clk) $fell(rst) |-> !done && !busy
    ) else begin
        fails++;
        $error("done or busy high after reset");
    end

endmodule

bind kcpu_exec kcpu_exec_asserts asserts_i (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .issue_op  (issue_op),
    .busy      (busy),
    .done      (done),
    .dec_valid (dec_valid),
    .dec       (dec)
);

//--- sim/kcpu_exec_tb.sv
`timescale 1ns/1ps
`include "kcpu_settings.svh"

module kcpu_exec_tb import kcpu_pkg::*; ();

    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        issue = 1'b0;
    issue_t      issue_op = '0;
    logic        busy;
    logic        done;
    result_t     res;

    int          seed = 32'h338c_4a4f;
    int          cyc = 0;
    int          val_errs = 0;
    int          proto_errs = 0;
    int          tmo_errs = 0;
    int          due;
    result_t     exp_r;
    logic [15:0] exp_m;
    result_t     exp_q[$];      // Expected results in issue order
    logic [15:0] mask_q[$];
    int          due_q[$];      // Cycle of done, -1 for a divide

    kcpu_exec dut_i (
        .clk      (clk),
        .rst      (rst),
        .issue    (issue),
        .issue_op (issue_op),
        .busy     (busy),
        .done     (done),
        .res      (res)
    );

    always #2 clk = ~clk;

    always @(posedge clk) cyc <= cyc + 1;

    function automatic result_t ref_model(input issue_t u);
        result_t     e;
        logic [15:0] m;
        logic [15:0] x;
        logic [15:0] y;
        logic [16:0] s;
        logic [ 7:0] lo;
        logic [ 7:0] fix;
        logic [ 8:0] bcd;
        int          sb;
        logic        cin;
        logic        wn;
        logic        wz;
        m   = u.w16 ? 16'hffff : 16'h00ff;
        sb  = u.w16 ? 15 : 7;
        x   = u.opnd0.word & m;
        y   = u.opnd1.word & m;
        lo  = u.opnd0.bytes.lo;
        cin = (u.op == op_adc || u.op == op_sbc) && u.cc.c;
        e   = '{rslt: u.opnd0.word, rslt_hi: 16'h0000, cc: u.cc};
        wn  = !(u.op inside {op_abx, op_mul, op_lmul, op_div, op_andcc, op_orcc});
        wz  = !(u.op inside {op_abs, op_abx, op_andcc, op_orcc});
        case (u.op)
            op_ld: begin
                e.rslt = y;
                e.cc.v = 1'b0;
            end
            op_add, op_adc: begin
                s      = x + y + cin;
                e.rslt = s[15:0] & m;
                e.cc.c = s[sb + 1];
                e.cc.v = x[sb] == y[sb] && e.rslt[sb] != x[sb];
                if (!u.w16)
                    e.cc.h = x[4] ^ y[4] ^ e.rslt[4];  // Carry into bit 4
            end
            op_sub, op_sbc, op_cmp: begin
                s      = x - y - cin;
                e.rslt = s[15:0] & m;
                e.cc.c = {1'b0, x} < {1'b0, y} + cin;  // Borrow
                e.cc.v = x[sb] != y[sb] && e.rslt[sb] != x[sb];
            end
            op_and, op_eor, op_or: begin
                e.rslt = u.op == op_and ? x & y : u.op == op_eor ? x ^ y : x | y;
                e.cc.v = 1'b0;
            end
            op_andcc: e.cc = u.cc & u.opnd1.bytes.lo;
            op_orcc:  e.cc = u.cc | u.opnd1.bytes.lo;
            op_clr, op_com: begin
                e.rslt = u.op == op_clr ? 16'h0000 : ~x & m;
                e.cc.c = u.op == op_com;
                e.cc.v = 1'b0;
            end
            op_neg: begin
                e.rslt = (16'h0000 - x) & m;
                e.cc.c = x != 16'h0000;
                e.cc.v = x[sb] == e.rslt[sb];
            end
            op_inc, op_dec: begin
                e.rslt = (u.op == op_inc ? x + 16'd1 : x - 16'd1) & m;
                e.cc.v = x[sb] != e.rslt[sb];
            end
            op_lsr, op_ror, op_asr: begin
                e.rslt     = x >> 1;
                e.rslt[sb] = u.op == op_ror ? u.cc.c : u.op == op_asr ? x[sb] : 1'b0;
                e.cc.c     = x[0];
            end
            op_asl, op_rol: begin
                e.rslt = ((x << 1) | (u.op == op_rol ? u.cc.c : 1'b0)) & m;
                e.cc.c = x[sb];
                e.cc.v = x[sb] != e.rslt[sb];
            end
            op_daa: begin
                fix    = {(u.cc.c || lo[7:4] > 4'h9 ||
                           (lo[7:4] > 4'h8 && lo[3:0] > 4'h9)) ? 4'h6 : 4'h0,
                          (u.cc.h || lo[3:0] > 4'h9) ? 4'h6 : 4'h0};
                bcd    = {1'b0, lo} + {1'b0, fix};
                e.rslt = {u.opnd0.bytes.hi, bcd[7:0]};
                e.cc.c = u.cc.c | bcd[8];
            end
            op_sex: e.rslt = {{8{lo[7]}}, lo};
            op_mul: begin
                e.rslt = u.opnd0.bytes.hi * lo;
                e.cc.c = e.rslt[7];
            end
            op_lmul: begin
                {e.rslt_hi, e.rslt} = u.opnd0.word * u.opnd1.word;
                e.cc.c = e.rslt_hi[15];
            end
            op_abs: begin
                if (x[sb])
                    e.rslt = (16'h0000 - x) & m;
                e.cc.c = 1'b0;
                e.cc.v = 1'b0;
            end
            op_abx: e.rslt = {8'h00, lo} + u.opnd1.word;
            op_div: begin
                if (u.opnd1.bytes.lo == 8'h00) begin
                    e.rslt    = 16'hffff;
                    e.rslt_hi = {8'h00, lo};
                end else begin
                    e.rslt    = u.opnd0.word / u.opnd1.bytes.lo;
                    e.rslt_hi = u.opnd0.word % u.opnd1.bytes.lo;
                end
                e.cc.v = u.opnd1.bytes.lo == 8'h00;
            end
        endcase
        if (wz)
            e.cc.z = (e.rslt & m) == 16'h0000;
        if (wn)
            e.cc.n = e.rslt[sb];
        return e;
    endfunction

    // Upper byte of an 8-bit result carries no meaning
    function automatic logic [15:0] word_mask(input issue_t u);
        if (u.w16 || u.op inside {op_daa, op_sex, op_mul, op_lmul, op_abx, op_div})
            return 16'hffff;
        return 16'h00ff;
    endfunction

    function automatic issue_t rand_op(input alu_op_e op, input logic w16);
        issue_t u;
        u.op         = op;
        u.w16        = w16;
        u.opnd0.word = 16'($random(seed));
        u.opnd1.word = 16'($random(seed));
        u.cc         = 8'($random(seed));
        if ($random(seed) % 8 == 0)
            u.opnd1 = u.opnd0;      // Reaches the zero results
        return u;
    endfunction

    task automatic check_word(input string name, input logic [15:0] got,
                              input logic [15:0] exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            val_errs++;
        end
    endtask

    task automatic check_cc(input cc_t got, input cc_t exp);
        if (got !== exp) begin
            $display("FAIL %0t res.cc got %b expected %b", $time, got, exp);
            val_errs++;
        end
    endtask

    always @(negedge clk) begin
        if (done === 1'b1) begin
            if (exp_q.size() == 0) begin
                $display("Done pulsed at %0t with no result outstanding", $time);
                proto_errs++;
            end else begin
                exp_r = exp_q.pop_front();
                exp_m = mask_q.pop_front();
                due   = due_q.pop_front();
                if (due >= 0 && due != cyc) begin
                    $display("Done at %0t came in cycle %0d instead of cycle %0d",
                             $time, cyc, due);
                    proto_errs++;
                end
                check_word("res.rslt", res.rslt & exp_m, exp_r.rslt & exp_m);
                check_word("res.rslt_hi", res.rslt_hi, exp_r.rslt_hi);
                check_cc(res.cc, exp_r.cc);
            end
        end
    end

    task automatic step();
        @(posedge clk);
        #0.5;
    endtask

    task automatic flush();
        exp_q.delete();
        mask_q.delete();
        due_q.delete();
    endtask

    // Leaves issue high so that calls run back to back
    task automatic put(input issue_t u);
        issue    = 1'b1;
        issue_op = u;
        exp_q.push_back(ref_model(u));
        mask_q.push_back(word_mask(u));
        due_q.push_back(u.op == op_div ? -1 : cyc + 2);
        step();
    endtask

    task automatic wait_empty(input int limit);
        int n;
        n = 0;
        while (exp_q.size() != 0 && n < limit) begin
            step();
            n++;
        end
        if (exp_q.size() != 0) begin
            $display("Timeout: %0d results missing after %0d cycles", exp_q.size(), limit);
            tmo_errs++;
            flush();
        end
    endtask

    task automatic wait_busy(input logic level, input int limit);
        int n;
        n = 0;
        while (busy !== level && n < limit) begin
            step();
            n++;
        end
        if (busy !== level) begin
            $display("Timeout: busy did not go to %0d within %0d cycles", level, limit);
            tmo_errs++;
        end
    endtask

    task automatic run_range(input alu_op_e first, input alu_op_e last, input int reps);
        for (int n = 0; n < reps; n++) begin
            for (int k = first; k <= last; k++) begin
                put(rand_op(alu_op_e'(k), 1'b0));
                put(rand_op(alu_op_e'(k), 1'b1));
            end
        end
        issue = 1'b0;
        wait_empty(8);
    endtask

    task automatic run_div(input logic zero, input logic w16);
        issue_t u;
        u = rand_op(op_div, w16);
        if (zero)
            u.opnd1.bytes.lo = 8'h00;
        put(u);
        issue = 1'b0;
        wait_busy(1'b1, 4);
        wait_busy(1'b0, `KCPU_DIV_STEPS + 4);
        wait_empty(4);
        put(rand_op(op_add, w16));      // Next op after the divide
        issue = 1'b0;
        wait_empty(8);
    endtask

    task automatic pulse_reset();
        rst   = 1'b1;
        issue = 1'b0;
        flush();
        step();
        if (busy !== 1'b0 || done !== 1'b0) begin
            $display("Busy or done still high at %0t during reset", $time);
            proto_errs++;
        end
        repeat (2) step();
        rst = 1'b0;
    endtask

    initial begin
        repeat (8) @(posedge clk);
        #0.5 rst = 1'b0;
        run_range(op_add, op_cmp, 20);
        run_range(op_ld, op_ld, 10);
        run_range(op_and, op_rol, 10);      // Logic, cc masks, unary, shifts
        run_range(op_daa, op_abx, 10);      // Byte views and multiplies
        for (int k = 0; k < 200; k++)
            put(rand_op(alu_op_e'($unsigned($random(seed)) % 27), 1'($random(seed))));
        issue = 1'b0;
        wait_empty(8);
        for (int k = 0; k < 12; k++)
            run_div(k % 3 == 0, k[0]);
        put(rand_op(op_div, 1'b1));
        issue = 1'b0;
        repeat (5) step();
        pulse_reset();                      // Divide in flight
        put(rand_op(op_add, 1'b0));
        pulse_reset();                      // Op still in decode
        run_range(op_sub, op_sub, 2);
        run_div(1'b0, 1'b0);
        $display("Errors: %0d value, %0d protocol, %0d timeout, %0d assertion",
                 val_errs, proto_errs, tmo_errs, dut_i.asserts_i.fails);
        if (val_errs + proto_errs + tmo_errs + dut_i.asserts_i.fails == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule
